/* hdl/FpFormatPkg.sv */
/*
 * Single-precision (binary32) format only. Widths are fixed localparams.
 * Flag and class encodings follow the RISC-V F extension.
 */
package FpFormatPkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int EXPONENT_WIDTH = 8;
    localparam int FRACTION_WIDTH = 23;
    localparam int FP_WIDTH = 1 + EXPONENT_WIDTH + FRACTION_WIDTH;
    localparam int WORD_WIDTH = 32;    // integer register width.
    localparam int FFLAGS_WIDTH = 5;
    localparam int CLASS_WIDTH = 10;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [FP_WIDTH-1:0] fpWord_t;
    typedef logic [EXPONENT_WIDTH-1:0] expField_t;
    typedef logic [FRACTION_WIDTH-1:0] fracField_t;
    typedef logic [FFLAGS_WIDTH-1:0] fflags_t;    // {NV, DZ, OF, UF, NX}.
    typedef logic [CLASS_WIDTH-1:0] fpClass_t;

    // flag bit positions.
    localparam int FFLAG_NV = 4;

    // FCLASS bit positions, in RISC-V order.
    localparam int CLASS_NEG_INF = 0;
    localparam int CLASS_NEG_NORMAL = 1;
    localparam int CLASS_NEG_SUBNORMAL = 2;
    localparam int CLASS_NEG_ZERO = 3;
    localparam int CLASS_POS_ZERO = 4;
    localparam int CLASS_POS_SUBNORMAL = 5;
    localparam int CLASS_POS_NORMAL = 6;
    localparam int CLASS_POS_INF = 7;
    localparam int CLASS_SNAN = 8;
    localparam int CLASS_QNAN = 9;

    localparam fpWord_t CANONICAL_NAN = 32'h7fc00000;

    // operand split into fields plus its category.
    typedef struct packed {
        logic sign;
        expField_t exponent;
        fracField_t fraction;
        logic isZero;
        logic isSubnormal;
        logic isInf;
        logic isNaN;
        logic isSignalingNaN;
    } FpOperand;

endpackage

/* hdl/FpOpPkg.sv */
/*
 * Operation encodings for the non-rounding FP functions only.
 * No FMA, divide or square root commands exist here.
 */
package FpOpPkg;

    // ------------------------------------------------------------------
    // sub-units and commands
    // ------------------------------------------------------------------
    typedef enum logic [1:0] {
        FpSubUnitType_Move,
        FpSubUnitType_Classifier,
        FpSubUnitType_Sign,
        FpSubUnitType_Comparator
    } FpSubUnitType;

    typedef enum logic {
        FpMoveCmd_ToInt,    // FMV.X.W.
        FpMoveCmd_ToFp      // FMV.W.X.
    } FpMoveCmd;

    typedef enum logic [1:0] {
        FpSignCmd_Inject,
        FpSignCmd_InjectNeg,
        FpSignCmd_InjectXor
    } FpSignCmd;

    typedef enum logic [2:0] {
        FpCmpCmd_Eq,
        FpCmpCmd_Lt,
        FpCmpCmd_Le,
        FpCmpCmd_Min,
        FpCmpCmd_Max
    } FpCmpCmd;

    // ------------------------------------------------------------------
    // pipeline payloads
    // ------------------------------------------------------------------
    typedef struct packed {
        FpSubUnitType unit;
        FpMoveCmd moveCmd;
        FpSignCmd signCmd;
        FpCmpCmd cmpCmd;
        FpFormatPkg::word_t intSrc1;
        FpFormatPkg::fpWord_t fpSrc1;
        FpFormatPkg::fpWord_t fpSrc2;
    } FpIssue;

    typedef struct packed {
        FpIssue issue;
        FpFormatPkg::FpOperand op1;
        FpFormatPkg::FpOperand op2;
    } FpDecoded;

    typedef struct packed {
        FpFormatPkg::word_t intResult;
        FpFormatPkg::fpWord_t fpResult;
        logic writeFlags;
        FpFormatPkg::fflags_t writeFlagsValue;
    } FpResult;

endpackage

/* hdl/FpOperandStage.sv */
/*
 * Captures one issued op per enable strobe, one clock latency.
 * flush wins over enable at the same edge. Payload is not reset.
 */
`timescale 1ns/100ps

module FpOperandStage (
    input  logic              clk,
    input  logic              arstN,
    input  logic              enable,
    input  logic              flush,
    input  FpOpPkg::FpIssue   issue,
    output FpOpPkg::FpDecoded decoded,
    output logic              decodedValid
);
    import FpFormatPkg::*;
    import FpOpPkg::*;

    FpDecoded decodedNext;
    logic capture;

    // split a float word into fields and category bits.
    function automatic FpOperand decodeOperand(input fpWord_t word);
        FpOperand op;
        logic expZero;
        logic expOnes;
        logic fracZero;
        op.sign = word[FP_WIDTH-1];
        op.exponent = word[FP_WIDTH-2 -: EXPONENT_WIDTH];
        op.fraction = word[FRACTION_WIDTH-1:0];
        expZero = (op.exponent == '0);
        expOnes = (op.exponent == '1);
        fracZero = (op.fraction == '0);
        op.isZero = expZero && fracZero;
        op.isSubnormal = expZero && !fracZero;
        op.isInf = expOnes && fracZero;
        op.isNaN = expOnes && !fracZero;
        // quiet bit is the fraction MSB.
        op.isSignalingNaN = op.isNaN && !op.fraction[FRACTION_WIDTH-1];
        return op;
    endfunction

    assign capture = enable && !flush;

    always_comb begin
        decodedNext.issue = issue;
        decodedNext.op1 = decodeOperand(issue.fpSrc1);
        decodedNext.op2 = decodeOperand(issue.fpSrc2);
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decodedValid <= 1'b0;
        end else begin
            decodedValid <= capture;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            decoded <= decodedNext;
        end
    end

    // a flushed edge neither validates nor loads an op in this stage.
    assert property (@(posedge clk) disable iff (!arstN)
                     flush |=> !decodedValid && $stable(decoded))
        else $error("operand stage took an op at a flushed edge.");

endmodule

/* hdl/FpClassifier.sv */
/*
 * FCLASS on operand 1. Purely combinational.
 * Mask is the ten-bit RISC-V class, zero-extended later.
 */
`timescale 1ns/100ps

module FpClassifier (
    input  FpOpPkg::FpDecoded     decoded,
    output FpFormatPkg::fpClass_t classMask
);
    import FpFormatPkg::*;

    FpOperand op;
    logic isNormal;

    assign op = decoded.op1;
    assign isNormal = !(op.isZero || op.isSubnormal || op.isInf || op.isNaN);

    always_comb begin
        classMask = '0;
        classMask[CLASS_NEG_INF] = op.sign && op.isInf;
        classMask[CLASS_NEG_NORMAL] = op.sign && isNormal;
        classMask[CLASS_NEG_SUBNORMAL] = op.sign && op.isSubnormal;
        classMask[CLASS_NEG_ZERO] = op.sign && op.isZero;
        classMask[CLASS_POS_ZERO] = !op.sign && op.isZero;
        classMask[CLASS_POS_SUBNORMAL] = !op.sign && op.isSubnormal;
        classMask[CLASS_POS_NORMAL] = !op.sign && isNormal;
        classMask[CLASS_POS_INF] = !op.sign && op.isInf;
        // NaN sign is ignored.
        classMask[CLASS_SNAN] = op.isSignalingNaN;
        classMask[CLASS_QNAN] = op.isNaN && !op.isSignalingNaN;
    end

    // category bits from the operand stage must be mutually exclusive.
    always_comb begin
        assert ($isunknown(classMask) || $onehot(classMask))
            else $error("FCLASS mask is not one-hot: %b.", classMask);
    end

endmodule

/* hdl/FpComparator.sv */
/*
 * FEQ/FLT/FLE and FMIN/FMAX, combinational. Only NV is ever raised.
 * FEQ is a quiet compare; FLT and FLE signal on any NaN.
 */
`timescale 1ns/100ps

module FpComparator (
    input  FpOpPkg::FpDecoded    decoded,
    output FpFormatPkg::word_t   cmpInt,
    output FpFormatPkg::fpWord_t cmpFp,
    output FpFormatPkg::fflags_t cmpFlags
);
    import FpFormatPkg::*;
    import FpOpPkg::*;

    FpOperand op1;
    FpOperand op2;
    fpWord_t src1;
    fpWord_t src2;
    logic anyNaN;
    logic anySNaN;
    logic bothZero;
    logic mag1Less;        // |op1| < |op2|.
    logic mag2Less;        // |op2| < |op1|.
    logic isEqual;
    logic isLess;          // zeros compare equal here.
    logic isLessSigned;    // -0 below +0, for min/max.
    fpWord_t minMaxPick;

    assign op1 = decoded.op1;
    assign op2 = decoded.op2;
    assign src1 = decoded.issue.fpSrc1;
    assign src2 = decoded.issue.fpSrc2;

    assign anyNaN = op1.isNaN || op2.isNaN;
    assign anySNaN = op1.isSignalingNaN || op2.isSignalingNaN;
    assign bothZero = op1.isZero && op2.isZero;
    assign mag1Less = {op1.exponent, op1.fraction} < {op2.exponent, op2.fraction};
    assign mag2Less = {op2.exponent, op2.fraction} < {op1.exponent, op1.fraction};
    assign isEqual = bothZero || (src1 == src2);
    assign isLessSigned = isLess || (bothZero && op1.sign && !op2.sign);

    always_comb begin
        if (bothZero) begin
            isLess = 1'b0;
        end else if (op1.sign != op2.sign) begin
            isLess = op1.sign;    // negative side is smaller.
        end else if (op1.sign) begin
            isLess = mag2Less;    // both negative, larger magnitude is smaller.
        end else begin
            isLess = mag1Less;
        end
    end

    // ------------------------------------------------------------------
    // result selection
    // ------------------------------------------------------------------
    always_comb begin
        if (op1.isNaN && op2.isNaN) begin
            minMaxPick = CANONICAL_NAN;
        end else if (op1.isNaN) begin
            minMaxPick = src2;
        end else if (op2.isNaN) begin
            minMaxPick = src1;
        end else if (decoded.issue.cmpCmd == FpCmpCmd_Min) begin
            minMaxPick = isLessSigned ? src1 : src2;
        end else begin
            minMaxPick = isLessSigned ? src2 : src1;
        end
    end

    always_comb begin
        cmpInt = '0;
        cmpFp = '0;
        cmpFlags = '0;
        case (decoded.issue.cmpCmd)
            FpCmpCmd_Eq: begin
                cmpInt[0] = isEqual && !anyNaN;
                cmpFlags[FFLAG_NV] = anySNaN;
            end
            FpCmpCmd_Lt: begin
                cmpInt[0] = isLess && !anyNaN;
                cmpFlags[FFLAG_NV] = anyNaN;
            end
            FpCmpCmd_Le: begin
                cmpInt[0] = (isLess || isEqual) && !anyNaN;
                cmpFlags[FFLAG_NV] = anyNaN;
            end
            FpCmpCmd_Min, FpCmpCmd_Max: begin
                cmpFp = minMaxPick;
                cmpFlags[FFLAG_NV] = anySNaN;
            end
            default: cmpFlags = '0;
        endcase
    end

endmodule

/* hdl/FpResultStage.sv */
/*
 * Final register stage. No back-pressure, so the result is valid
 * only in the done cycle. writeFlags drops whenever done is low.
 */
`timescale 1ns/100ps

module FpResultStage (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  flush,
    input  FpOpPkg::FpDecoded     decoded,
    input  logic                  decodedValid,
    input  FpFormatPkg::fpClass_t classMask,
    input  FpFormatPkg::word_t    cmpInt,
    input  FpFormatPkg::fpWord_t  cmpFp,
    input  FpFormatPkg::fflags_t  cmpFlags,
    output FpOpPkg::FpResult      result,
    output logic                  done
);
    import FpFormatPkg::*;
    import FpOpPkg::*;

    FpResult resultNext;
    logic injectedSign;
    logic retire;

    assign retire = decodedValid && !flush;

    always_comb begin
        case (decoded.issue.signCmd)
            FpSignCmd_Inject: injectedSign = decoded.op2.sign;
            FpSignCmd_InjectNeg: injectedSign = !decoded.op2.sign;
            default: injectedSign = decoded.op1.sign ^ decoded.op2.sign;
        endcase
    end

    // ------------------------------------------------------------------
    // select by sub-unit
    // ------------------------------------------------------------------
    always_comb begin
        resultNext = '0;
        case (decoded.issue.unit)
            FpSubUnitType_Move: begin
                if (decoded.issue.moveCmd == FpMoveCmd_ToInt) begin
                    resultNext.intResult = decoded.issue.fpSrc1;    // raw bits.
                end else begin
                    resultNext.fpResult = decoded.issue.intSrc1;
                end
            end
            FpSubUnitType_Classifier: resultNext.intResult = word_t'(classMask);
            FpSubUnitType_Sign: begin
                resultNext.fpResult = {injectedSign, decoded.op1.exponent,
                                       decoded.op1.fraction};
            end
            default: begin    // comparator.
                resultNext.intResult = cmpInt;
                resultNext.fpResult = cmpFp;
                resultNext.writeFlags = 1'b1;
                resultNext.writeFlagsValue = cmpFlags;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result <= '0;
            done <= 1'b0;
        end else begin
            done <= retire;
            if (retire) begin
                result <= resultNext;
            end else begin
                result.writeFlags <= 1'b0;
            end
        end
    end

    // flags are written only in a done cycle, and only by a compare op.
    assert property (@(posedge clk) disable iff (!arstN)
                     result.writeFlags |-> done
                     && $past(decoded.issue.unit) == FpSubUnitType_Comparator)
        else $error("writeFlags high outside a comparator done.");

endmodule

/* hdl/FpUnit.sv */
/*
 * Non-rounding single-precision FP unit. Fixed two-clock latency,
 * one op per cycle, flush cancels everything in flight.
 */
`timescale 1ns/100ps

module FpUnit (
    input  logic             clk,
    input  logic             arstN,
    input  logic             enable,
    input  logic             flush,
    input  FpOpPkg::FpIssue  issue,
    output FpOpPkg::FpResult result,
    output logic             done
);
    import FpFormatPkg::*;
    import FpOpPkg::*;

    FpDecoded decoded;
    logic decodedValid;
    fpClass_t classMask;
    word_t cmpInt;
    fpWord_t cmpFp;
    fflags_t cmpFlags;

    // ------------------------------------------------------------------
    // input side
    // ------------------------------------------------------------------
    FpOperandStage u_FpOperandStage (
        .clk(clk),
        .arstN(arstN),
        .enable(enable),
        .flush(flush),
        .issue(issue),
        .decoded(decoded),
        .decodedValid(decodedValid)
    );

    FpClassifier u_FpClassifier (.decoded(decoded), .classMask(classMask));

    FpComparator u_FpComparator (
        .decoded(decoded),
        .cmpInt(cmpInt),
        .cmpFp(cmpFp),
        .cmpFlags(cmpFlags)
    );

    // ------------------------------------------------------------------
    // output side
    // ------------------------------------------------------------------
    FpResultStage u_FpResultStage (
        .clk(clk),
        .arstN(arstN),
        .flush(flush),
        .decoded(decoded),
        .decodedValid(decodedValid),
        .classMask(classMask),
        .cmpInt(cmpInt),
        .cmpFp(cmpFp),
        .cmpFlags(cmpFlags),
        .result(result),
        .done(done)
    );

endmodule

/* tests/FpUnitChecker.sv */
/*
 * Scoreboard for FpUnit. Expected results are queued in issue order and
 * popped on each done. The DUT never reorders, so order has to match.
 * Each done must arrive two clocks after its issue.
 */
`timescale 1ns/100ps

module FpUnitChecker (
    input  logic             clk,
    input  logic             arstN,
    input  logic             expectValid,
    input  FpOpPkg::FpResult expected,
    input  logic [127:0]     expectName,    // sixteen ASCII characters.
    input  logic             done,
    input  FpOpPkg::FpResult result,
    output int               mismatchCount,
    output int               unexpectedCount,
    output int               pendingCount
);
    import FpFormatPkg::*;
    import FpOpPkg::*;

    localparam int LATENCY = 2;    // clocks from issue to done.

    FpResult expectQueue[$];
    logic [127:0] nameQueue[$];
    int stampQueue[$];
    FpResult head;
    logic [127:0] headName;
    int headStamp;
    int cycle;
    int mismatches;
    int unexpected;

    task automatic checkField(input logic [127:0] testName, input string field,
                              input word_t expVal, input word_t actVal);
        if (actVal !== expVal) begin
            $display("[FAIL] %s %s expected %h actual %h", testName, field, expVal, actVal);
            mismatches++;
        end
    endtask

    // ------------------------------------------------------------------
    // push on issue, pop and compare on done
    // ------------------------------------------------------------------
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            expectQueue.delete();
            nameQueue.delete();
            stampQueue.delete();
            cycle = 0;
            mismatches = 0;
            unexpected = 0;
        end else begin
            cycle++;
            if (expectValid) begin
                expectQueue.push_back(expected);
                nameQueue.push_back(expectName);
                stampQueue.push_back(cycle);
            end
            if (done) begin
                if (expectQueue.size() == 0) begin
                    $display("done seen at %0t with no operation outstanding", $time);
                    unexpected++;
                end else begin
                    head = expectQueue.pop_front();
                    headName = nameQueue.pop_front();
                    headStamp = stampQueue.pop_front();
                    checkField(headName, "latency", word_t'(LATENCY),
                               word_t'(cycle - headStamp));
                    checkField(headName, "intResult", head.intResult, result.intResult);
                    checkField(headName, "fpResult", head.fpResult, result.fpResult);
                    checkField(headName, "writeFlags", word_t'(head.writeFlags),
                               word_t'(result.writeFlags));
                    checkField(headName, "flags", word_t'(head.writeFlagsValue),
                               word_t'(result.writeFlagsValue));
                end
            end
        end
        mismatchCount <= mismatches;
        unexpectedCount <= unexpected;
        pendingCount <= expectQueue.size();    // ops still waiting for done.
    end

endmodule

/* tests/FpUnitTb.sv */
/*
 * Testbench for FpUnit. One table entry is issued per clock, so ops
 * overlap in the pipeline. Comparing is done in FpUnitChecker.
 */
`timescale 1ns/100ps

module FpUnitTb;
    import FpFormatPkg::*;
    import FpOpPkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam int TIMEOUT_MARGIN = 20;
    localparam int NAME_CHARS = 16;

    typedef logic [8*NAME_CHARS-1:0] testName_t;

    // float operands used by the table.
    localparam fpWord_t POS_ZERO = 32'h00000000;
    localparam fpWord_t NEG_ZERO = 32'h80000000;
    localparam fpWord_t POS_ONE = 32'h3f800000;
    localparam fpWord_t NEG_ONE = 32'hbf800000;
    localparam fpWord_t POS_TWO = 32'h40000000;
    localparam fpWord_t NEG_TWO = 32'hc0000000;
    localparam fpWord_t POS_INF = 32'h7f800000;
    localparam fpWord_t NEG_INF = 32'hff800000;
    localparam fpWord_t POS_SUB = 32'h00000001;
    localparam fpWord_t NEG_SUB = 32'h807fffff;
    localparam fpWord_t QNAN = 32'h7fc00000;
    localparam fpWord_t NEG_QNAN = 32'hffc00001;
    localparam fpWord_t SNAN = 32'h7f800001;

    logic clk;
    logic arstN;
    logic enable;
    logic flush;
    FpIssue issue;
    FpResult result;
    logic done;

    logic expectValid;
    FpResult expected;
    testName_t expectName;
    int mismatchCount;
    int unexpectedCount;
    int pendingCount;

    FpIssue issueTable[$];
    FpResult expectTable[$];
    testName_t nameTable[$];
    bit cancelTable[$];    // set when the entry is flushed right after issue.
    bit tableBuilt;
    integer seed;
    int totalErrors;

    FpUnit u_FpUnit (
        .clk(clk),
        .arstN(arstN),
        .enable(enable),
        .flush(flush),
        .issue(issue),
        .result(result),
        .done(done)
    );

    FpUnitChecker u_FpUnitChecker (
        .clk(clk),
        .arstN(arstN),
        .expectValid(expectValid),
        .expected(expected),
        .expectName(expectName),
        .done(done),
        .result(result),
        .mismatchCount(mismatchCount),
        .unexpectedCount(unexpectedCount),
        .pendingCount(pendingCount)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------
    // table construction
    // ------------------------------------------------------------------
    function automatic testName_t packName(input string s);
        testName_t v;
        v = {NAME_CHARS{8'h20}};    // space padded, left aligned.
        for (int i = 0; i < s.len() && i < NAME_CHARS; i++) begin
            v[8*(NAME_CHARS-1-i) +: 8] = s[i];
        end
        return v;
    endfunction

    function automatic FpIssue makeIssue(input FpSubUnitType unit, input fpWord_t a,
                                         input fpWord_t b);
        FpIssue op;
        op = '0;
        op.unit = unit;
        op.fpSrc1 = a;
        op.fpSrc2 = b;
        return op;
    endfunction

    task automatic pushEntry(input string name, input FpIssue op, input FpResult exp,
                             input bit cancel);
        issueTable.push_back(op);
        expectTable.push_back(exp);
        nameTable.push_back(packName(name));
        cancelTable.push_back(cancel);
    endtask

    task automatic addMove(input string name, input FpMoveCmd cmd, input word_t value);
        FpIssue op;
        FpResult exp;
        op = makeIssue(FpSubUnitType_Move, value, ~value);
        op.moveCmd = cmd;
        exp = '0;
        if (cmd == FpMoveCmd_ToInt) begin
            exp.intResult = value;    // raw bits, no conversion.
        end else begin
            op.intSrc1 = value;
            op.fpSrc1 = ~value;       // must not leak into the result.
            exp.fpResult = value;
        end
        pushEntry(name, op, exp, 1'b0);
    endtask

    task automatic addClass(input string name, input fpWord_t a, input int bitPos);
        FpResult exp;
        exp = '0;
        exp.intResult = word_t'(1) << bitPos;
        pushEntry(name, makeIssue(FpSubUnitType_Classifier, a, POS_ZERO), exp, 1'b0);
    endtask

    task automatic addSign(input string name, input FpSignCmd cmd, input fpWord_t a,
                           input fpWord_t b, input fpWord_t expFp);
        FpIssue op;
        FpResult exp;
        op = makeIssue(FpSubUnitType_Sign, a, b);
        op.signCmd = cmd;
        exp = '0;
        exp.fpResult = expFp;
        pushEntry(name, op, exp, 1'b0);
    endtask

    task automatic addCompare(input string name, input FpCmpCmd cmd, input fpWord_t a,
                              input fpWord_t b, input logic expBit, input logic nv,
                              input bit cancel);
        FpIssue op;
        FpResult exp;
        op = makeIssue(FpSubUnitType_Comparator, a, b);
        op.cmpCmd = cmd;
        exp = '0;
        exp.intResult[0] = expBit;
        exp.writeFlags = 1'b1;
        exp.writeFlagsValue[4] = nv;    // NV is the top flag bit.
        pushEntry(name, op, exp, cancel);
    endtask

    task automatic addMinMax(input string name, input FpCmpCmd cmd, input fpWord_t a,
                             input fpWord_t b, input fpWord_t expFp, input logic nv);
        FpIssue op;
        FpResult exp;
        op = makeIssue(FpSubUnitType_Comparator, a, b);
        op.cmpCmd = cmd;
        exp = '0;
        exp.fpResult = expFp;
        exp.writeFlags = 1'b1;
        exp.writeFlagsValue[4] = nv;
        pushEntry(name, op, exp, 1'b0);
    endtask

    task automatic buildTable();
        word_t value;
        for (int k = 0; k < 2; k++) begin
            value = $random(seed);
            addMove($sformatf("moveToInt%0d", k), FpMoveCmd_ToInt, value);
            value = $random(seed);
            addMove($sformatf("moveToFp%0d", k), FpMoveCmd_ToFp, value);
        end
        // one mask bit per category, in RISC-V order.
        addClass("classNegInf", NEG_INF, 0);
        addClass("classNegNormal", NEG_TWO, 1);
        addClass("classNegSub", NEG_SUB, 2);
        addClass("classNegZero", NEG_ZERO, 3);
        addClass("classPosZero", POS_ZERO, 4);
        addClass("classPosSub", POS_SUB, 5);
        addClass("classPosNormal", POS_ONE, 6);
        addClass("classPosInf", POS_INF, 7);
        addClass("classSNaN", SNAN, 8);
        addClass("classQNaN", NEG_QNAN, 9);
        // this one is flushed and must never return.
        addCompare("flushedEq", FpCmpCmd_Eq, POS_ONE, POS_ONE, 1'b1, 1'b0, 1'b1);
        addSign("sgnjNeg", FpSignCmd_Inject, POS_ONE, NEG_ONE, NEG_ONE);
        addSign("sgnjnPos", FpSignCmd_InjectNeg, POS_ONE, NEG_ONE, POS_ONE);
        addSign("sgnjxNegNeg", FpSignCmd_InjectXor, NEG_ONE, NEG_ONE, POS_ONE);
        addSign("sgnjQNaN", FpSignCmd_Inject, QNAN, NEG_ZERO, 32'hffc00000);
        addSign("sgnjnSNaN", FpSignCmd_InjectNeg, SNAN, SNAN, 32'hff800001);
        addSign("sgnjxNegQNaN", FpSignCmd_InjectXor, NEG_QNAN, POS_ZERO, NEG_QNAN);
        addCompare("eqOne", FpCmpCmd_Eq, POS_ONE, POS_ONE, 1'b1, 1'b0, 1'b0);
        addCompare("eqZeros", FpCmpCmd_Eq, NEG_ZERO, POS_ZERO, 1'b1, 1'b0, 1'b0);
        addCompare("eqDiffer", FpCmpCmd_Eq, POS_ONE, POS_TWO, 1'b0, 1'b0, 1'b0);
        addCompare("ltMixedSign", FpCmpCmd_Lt, NEG_ONE, POS_ONE, 1'b1, 1'b0, 1'b0);
        addCompare("ltGreater", FpCmpCmd_Lt, POS_TWO, POS_ONE, 1'b0, 1'b0, 1'b0);
        addCompare("ltBothNeg", FpCmpCmd_Lt, NEG_TWO, NEG_ONE, 1'b1, 1'b0, 1'b0);
        addCompare("ltZeros", FpCmpCmd_Lt, NEG_ZERO, POS_ZERO, 1'b0, 1'b0, 1'b0);
        addCompare("leZeros", FpCmpCmd_Le, NEG_ZERO, POS_ZERO, 1'b1, 1'b0, 1'b0);
        addCompare("eqQNaN", FpCmpCmd_Eq, QNAN, POS_ONE, 1'b0, 1'b0, 1'b0);
        addCompare("ltQNaN", FpCmpCmd_Lt, QNAN, POS_ONE, 1'b0, 1'b1, 1'b0);
        addCompare("leQNaN", FpCmpCmd_Le, POS_ONE, QNAN, 1'b0, 1'b1, 1'b0);
        addCompare("eqSNaN", FpCmpCmd_Eq, SNAN, POS_ONE, 1'b0, 1'b1, 1'b0);
        addCompare("ltSNaN", FpCmpCmd_Lt, POS_ONE, SNAN, 1'b0, 1'b1, 1'b0);
        addCompare("leSNaN", FpCmpCmd_Le, SNAN, SNAN, 1'b0, 1'b1, 1'b0);
        addMinMax("minZeros", FpCmpCmd_Min, POS_ZERO, NEG_ZERO, NEG_ZERO, 1'b0);
        addMinMax("maxZeros", FpCmpCmd_Max, NEG_ZERO, POS_ZERO, POS_ZERO, 1'b0);
        addMinMax("minMixed", FpCmpCmd_Min, POS_ONE, NEG_TWO, NEG_TWO, 1'b0);
        addMinMax("maxMixed", FpCmpCmd_Max, POS_ONE, NEG_TWO, POS_ONE, 1'b0);
        addMinMax("minOneQNaN", FpCmpCmd_Min, QNAN, POS_ONE, POS_ONE, 1'b0);
        addMinMax("maxOneQNaN", FpCmpCmd_Max, POS_TWO, QNAN, POS_TWO, 1'b0);
        addMinMax("minOneSNaN", FpCmpCmd_Min, SNAN, NEG_ONE, NEG_ONE, 1'b1);
        addMinMax("maxTwoQNaN", FpCmpCmd_Max, NEG_QNAN, QNAN, 32'h7fc00000, 1'b0);
        addMinMax("minTwoNaN", FpCmpCmd_Min, SNAN, NEG_QNAN, 32'h7fc00000, 1'b1);
    endtask

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial begin
        seed = 32'h86fb;
        tableBuilt = 1'b0;
        arstN = 1'b0;
        enable = 1'b0;
        flush = 1'b0;
        issue = '0;
        expectValid = 1'b0;
        expected = '0;
        expectName = '0;
        buildTable();
        tableBuilt = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;

        for (int i = 0; i < issueTable.size(); i++) begin
            @(posedge clk);
            enable <= 1'b1;
            flush <= 1'b0;
            issue <= issueTable[i];
            expectValid <= !cancelTable[i];
            expected <= expectTable[i];
            expectName <= nameTable[i];
            if (cancelTable[i]) begin
                @(posedge clk);
                enable <= 1'b0;
                expectValid <= 1'b0;
                flush <= 1'b1;    // kills the op while it sits in the operand stage.
            end
        end
        @(posedge clk);
        enable <= 1'b0;
        expectValid <= 1'b0;
        flush <= 1'b0;

        while (pendingCount != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);    // room for a stray done to show up.

        if (pendingCount != 0) begin
            $display("%0d operations never returned a done", pendingCount);
        end
        totalErrors = mismatchCount + unexpectedCount + pendingCount;
        $display("errors: %0d mismatched fields, %0d unexpected done, %0d missing done",
                 mismatchCount, unexpectedCount, pendingCount);
        if (totalErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog, sized from the table length.
    initial begin
        wait (tableBuilt);
        #((issueTable.size() + TIMEOUT_MARGIN) * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles",
                 issueTable.size() + TIMEOUT_MARGIN);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* FpUnit.f */
hdl/FpFormatPkg.sv
hdl/FpOpPkg.sv
hdl/FpOperandStage.sv
hdl/FpClassifier.sv
hdl/FpComparator.sv
hdl/FpResultStage.sv
hdl/FpUnit.sv
tests/FpUnitChecker.sv
tests/FpUnitTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# Builds the FpUnit testbench with Verilator and runs it.
# Exit status is zero only when the pass line shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module FpUnitTb \
    -f FpUnit.f \
    -o simFpUnit \
    && ./obj_dir/simFpUnit | tee /dev/stderr | grep -Fx "=== PASS ===" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
